//--- compile.f
verilog/cachePkg.sv
verilog/victimLfsr.sv
verilog/tagStore.sv
verilog/dataStore.sv
verilog/cacheControl.sv
verilog/cacheTop.sv
verif/cacheAsserts_asserts.sv
verif/cacheTb.sv

//--- runSim.sh
#!/bin/sh
# build the cache testbench with verilator, run it, then search the log
rm -f sim.log
verilator --binary --timing --assert --top-module cacheTb -Mdir obj_dir -f compile.f \
    && ./obj_dir/VcacheTb | tee sim.log \
    || { echo "build or run did not complete"; exit 1; }
grep -q "Simulation FAILED" sim.log && { echo "result: fail"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "result: run ended without a verdict"; exit 1; }
echo "result: pass"

//--- verif/cacheTb.sv
module cacheTb;
    import cachePkg::*;

    localparam int memBytes      = 4096;
    localparam int accessTimeout = 400;
    localparam int evictLimit    = 48;

    logic clock = 1'b0;
    logic reset;
    logic valid;
    logic write;
    addrT addr;
    wordT wdata;
    maskT wmask;
    wordT rdata;
    logic dataOk;
    logic arValid;
    logic arReady = 1'b0;
    addrT arAddr;
    logic rValid = 1'b0;
    logic rLast = 1'b0;
    wordT rData = '0;
    logic rReady;
    logic awValid;
    logic awReady = 1'b0;
    addrT awAddr;
    logic wValid;
    logic wReady = 1'b0;
    wordT wData;
    logic wLast;
    logic bValid = 1'b0;
    logic bReady;

    // backing memory and the bytes the cpu should see
    logic [7:0] mem [memBytes];
    logic [7:0] shadow [memBytes];
    logic       memFilled = 1'b0;
    addrT       lineBase [8];

    // memory model bookkeeping
    logic arTake = 1'b0;
    logic rTake = 1'b0;
    logic awTake = 1'b0;
    logic wTake = 1'b0;
    logic readBusy;
    logic writeBusy;
    addrT arPending;
    addrT awPending;
    wordT wPending;
    logic wLastPending;
    int   readBase;
    int   readBeat;
    int   writeBase;
    int   writeBeat;
    int   arCount = 0;
    int   awCount = 0;
    addrT lastAwBase = '0;

    // counters, one set per process
    int cmpChecks = 0;
    int cmpErrors = 0;
    int memChecks = 0;
    int memErrors = 0;
    int seqChecks = 0;
    int seqErrors = 0;

    cacheTop #(.lfsrSeed(16'h5a3c)) UUT (
        .clock(clock), .reset(reset),
        .valid(valid), .write(write), .addr(addr), .wdata(wdata), .wmask(wmask),
        .rdata(rdata), .dataOk(dataOk),
        .arValid(arValid), .arReady(arReady), .arAddr(arAddr),
        .rValid(rValid), .rLast(rLast), .rData(rData), .rReady(rReady),
        .awValid(awValid), .awReady(awReady), .awAddr(awAddr),
        .wValid(wValid), .wReady(wReady), .wData(wData), .wLast(wLast),
        .bValid(bValid), .bReady(bReady)
    );

    always #4 clock = ~clock;

    // aligned read word, zero past the line end
    function automatic wordT expectedRead(input addrT a);
        wordT result;
        int   off;
        result = '0;
        off = int'(a[3:0]);
        for (int i = 0; i < 8; i++) begin
            if (off + i < 16) begin
                result[i*8 +: 8] = shadow[int'(a[11:0]) + i];
            end
        end
        return result;
    endfunction

    function automatic int errorTotal();
        return cmpErrors + memErrors + seqErrors;
    endfunction

    // every completed read against the shadow bytes
    always @(negedge clock) begin
        if (!reset && dataOk && !write) begin
            cmpChecks++;
            assert (rdata == expectedRead(addr)) else begin
                $display("** Error at %0t: read 0x%h got 0x%h expected 0x%h",
                         $time, addr, rdata, expectedRead(addr));
                cmpErrors++;
            end
        end
    end

    // memory side: retire last edge's transfers, drive, then note the next ones
    always @(negedge clock) begin
        if (reset) begin
            if (!memFilled) begin
                for (int i = 0; i < memBytes; i++) begin
                    mem[i] = 8'($urandom);
                end
                memFilled = 1'b1;
            end
            arReady = 1'b0;
            rValid = 1'b0;
            rLast = 1'b0;
            awReady = 1'b0;
            wReady = 1'b0;
            arTake = 1'b0;
            rTake = 1'b0;
            awTake = 1'b0;
            wTake = 1'b0;
            readBusy = 1'b0;
            writeBusy = 1'b0;
            readBeat = 0;
            writeBeat = 0;
        end else begin
            if (arTake) begin
                arCount++;
                readBusy = 1'b1;
                readBeat = 0;
                readBase = int'(arPending[11:0]);
            end
            if (rTake) begin
                if (readBeat == 1) begin
                    readBusy = 1'b0;
                    readBeat = 0;
                end else begin
                    readBeat = 1;
                end
            end
            if (awTake) begin
                awCount++;
                writeBusy = 1'b1;
                writeBeat = 0;
                writeBase = int'(awPending[11:0]);
                lastAwBase = awPending;
            end
            if (wTake) begin
                memChecks++;
                assert (writeBusy && wLastPending == (writeBeat == 1)) else begin
                    $display("** Error at %0t: write beat %0d outside a two beat burst",
                             $time, writeBeat);
                    memErrors++;
                end
                // written-back bytes must be what the cpu last wrote
                for (int i = 0; i < 8; i++) begin
                    assert (wPending[i*8 +: 8] == shadow[writeBase + writeBeat*8 + i]) else begin
                        $display("** Error at %0t: write-back byte 0x%h got 0x%h", $time,
                                 writeBase + writeBeat*8 + i, wPending[i*8 +: 8]);
                        memErrors++;
                    end
                    mem[writeBase + writeBeat*8 + i] = wPending[i*8 +: 8];
                end
                if (wLastPending) begin
                    writeBusy = 1'b0;
                    writeBeat = 0;
                end else begin
                    writeBeat++;
                end
            end
            // two beats end the refill
            if (!readBusy) begin
                assert (!rReady) else begin
                    $display("** Error at %0t: rReady high outside a read burst", $time);
                    memErrors++;
                end
            end
            // write responses are always accepted
            memChecks++;
            assert (bReady) else begin
                $display("** Error at %0t: bReady low", $time);
                memErrors++;
            end
            arReady = $urandom_range(2) != 0;
            awReady = $urandom_range(2) != 0;
            wReady = $urandom_range(3) != 0;
            // a raised rValid stays until taken
            if (!rValid || rTake) begin
                rValid = readBusy && ($urandom_range(3) != 0);
            end
            rLast = rValid && readBeat == 1;
            for (int i = 0; i < 8; i++) begin
                rData[i*8 +: 8] = mem[(readBase + readBeat*8 + i) % memBytes];
            end
            arTake = arValid && arReady;
            if (arTake) begin
                arPending = arAddr;
                memChecks++;
                assert (arAddr == {addr[31:4], 4'b0000}) else begin
                    $display("** Error at %0t: ar address 0x%h for request 0x%h",
                             $time, arAddr, addr);
                    memErrors++;
                end
            end
            rTake = rValid && rReady;
            awTake = awValid && awReady;
            awPending = awAddr;
            wTake = wValid && wReady;
            wPending = wData;
            wLastPending = wLast;
        end
    end

    task automatic checkValue(input string what, input int got, input int expected);
        seqChecks++;
        assert (got == expected) else begin
            $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, expected);
            seqErrors++;
        end
    endtask

    task automatic reportTest(input int num, input string name, input int errBefore);
        int found;
        found = errorTotal() - errBefore;
        if (found == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, found);
        end
    endtask

    // one cpu access, request held until dataOk
    task automatic access(input logic isWrite, input addrT a, input wordT d, input maskT m,
                          output int waitCycles);
        int n;
        @(negedge clock);
        valid = 1'b1;
        write = isWrite;
        addr = a;
        wdata = d;
        wmask = m;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!dataOk && n < accessTimeout);
        if (!dataOk) begin
            $display("timeout: no dataOk for address 0x%h after %0d cycles", a, n);
            $display("Simulation FAILED");
            $finish;
        end else begin
            if (isWrite) begin
                for (int i = 0; i < 8; i++) begin
                    if (m[i]) begin
                        shadow[int'(a[11:0]) + i] = d[i*8 +: 8];
                    end
                end
            end
            waitCycles = n;
            @(negedge clock);
            valid = 1'b0;
        end
    endtask

    initial begin
        int   waitCycles;
        int   arBefore;
        int   awBefore;
        int   errBefore;
        int   size;
        int   tries;
        addrT a;
        void'($urandom(32'h9397));
        reset = 1'b1;
        valid = 1'b0;
        write = 1'b0;
        addr = '0;
        wdata = '0;
        wmask = '0;

        // reset outputs, five cycles held and one after
        errBefore = errorTotal();
        repeat (5) begin
            @(negedge clock);
            checkValue("reset outputs", int'({dataOk, arValid, awValid, wValid, rReady}), 0);
        end
        reset = 1'b0;
        @(negedge clock);
        checkValue("outputs after reset", int'({dataOk, arValid, awValid, wValid, rReady}), 0);
        reportTest(1, "reset outputs", errBefore);
        for (int i = 0; i < memBytes; i++) begin
            shadow[i] = mem[i];
        end

        // one cold line per set 0..7
        errBefore = errorTotal();
        for (int s = 0; s < 8; s++) begin
            a = {20'b0, 4'($urandom), 4'(s), 4'($urandom)};
            lineBase[s] = {a[31:4], 4'b0000};
            arBefore = arCount;
            awBefore = awCount;
            access(1'b0, a, '0, '0, waitCycles);
            checkValue("refills per cold read", arCount - arBefore, 1);
            checkValue("write-backs on cold read", awCount - awBefore, 0);
        end
        reportTest(2, "cold read miss", errBefore);

        // hits answer in lookup with no bus traffic
        errBefore = errorTotal();
        for (int s = 0; s < 8; s++) begin
            arBefore = arCount;
            awBefore = awCount;
            access(1'b0, lineBase[s] | addrT'($urandom_range(15)), '0, '0, waitCycles);
            checkValue("read hit latency", waitCycles, 1);
            checkValue("bus transfers on hit", arCount - arBefore + awCount - awBefore, 0);
        end
        reportTest(3, "read hit latency", errBefore);

        // 1, 2, 4 and 8 byte writes, then whole lines read back
        errBefore = errorTotal();
        for (int k = 0; k < 16; k++) begin
            size = 1 << (k % 4);
            a = lineBase[k % 8] | addrT'($urandom_range(16 - size));
            access(1'b1, a, {$urandom, $urandom}, maskT'((1 << size) - 1), waitCycles);
            checkValue("write hit latency", waitCycles, 1);
        end
        for (int s = 0; s < 8; s++) begin
            access(1'b0, lineBase[s], '0, '0, waitCycles);
            access(1'b0, lineBase[s] | 32'd8, '0, '0, waitCycles);
        end
        reportTest(4, "masked writes", errBefore);

        // other tags in each set until the dirty line goes out
        errBefore = errorTotal();
        for (int s = 0; s < 8; s++) begin
            awBefore = awCount;
            tries = 0;
            while (awCount == awBefore && tries < evictLimit) begin
                a = lineBase[s];
                a[11:8] = 4'(int'(lineBase[s][11:8]) + 1 + tries % 15);
                access(1'b0, a | addrT'($urandom_range(15)), '0, '0, waitCycles);
                tries++;
            end
            checkValue("write-backs per set", awCount - awBefore, 1);
            checkValue("write-back base", int'(lastAwBase), int'(lineBase[s]));
            access(1'b0, lineBase[s], '0, '0, waitCycles);
            access(1'b0, lineBase[s] | 32'd8, '0, '0, waitCycles);
        end
        reportTest(5, "dirty eviction", errBefore);

        $display("checks %0d, errors %0d, refills %0d, write-backs %0d",
                 cmpChecks + memChecks + seqChecks, errorTotal(), arCount, awCount);
        if (errorTotal() == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verif/cacheAsserts_asserts.sv
module cacheAsserts (
    input logic                 clock,
    input logic                 reset,
    input logic                 valid,
    input logic                 dataOk,
    input logic                 arValid,
    input logic                 arReady,
    input logic                 awValid,
    input logic                 wValid,
    input logic                 wLast,
    input logic                 rValid,
    input logic                 rLast,
    input cachePkg::cacheStateT state
);
    import cachePkg::*;

    // done only while the cpu holds its request
    doneWithRequest: assert property (@(posedge clock) disable iff (reset) dataOk |-> valid)
        else $error("dataOk raised without valid");

    // one address channel at a time
    oneAddressChannel: assert property (@(posedge clock) disable iff (reset)
        !(arValid && awValid))
        else $error("arValid and awValid high together");

    // last beat flag belongs to a valid beat
    lastWithValid: assert property (@(posedge clock) disable iff (reset) wLast |-> wValid)
        else $error("wLast without wValid");

    // read address held until accepted
    arHeld: assert property (@(posedge clock) disable iff (reset)
        arValid && !arReady |=> arValid)
        else $error("arValid dropped before arReady");

    // lookup right after the last refill beat finds the new line
    refillThenHit: assert property (@(posedge clock) disable iff (reset)
        state == stRefill && rValid && rLast |=> dataOk)
        else $error("lookup after refill did not hit");

endmodule

bind cacheTop cacheAsserts protocolChecks (
    .clock(clock), .reset(reset), .valid(valid), .dataOk(dataOk),
    .arValid(arValid), .arReady(arReady), .awValid(awValid),
    .wValid(wValid), .wLast(wLast), .rValid(rValid), .rLast(rLast),
    .state(control.state)
);

//--- verilog/cacheTop.sv
module cacheTop #(
    parameter logic [15:0] lfsrSeed = 16'd1
) (
    input  logic           clock,
    input  logic           reset,
    // cpu request and done
    input  logic           valid,
    input  logic           write,
    input  cachePkg::addrT addr,
    input  cachePkg::wordT wdata,
    input  cachePkg::maskT wmask,
    output cachePkg::wordT rdata,
    output logic           dataOk,
    // read address and read data
    output logic           arValid,
    input  logic           arReady,
    output cachePkg::addrT arAddr,
    input  logic           rValid,
    input  logic           rLast,
    input  cachePkg::wordT rData,
    output logic           rReady,
    // write address and write data
    output logic           awValid,
    input  logic           awReady,
    output cachePkg::addrT awAddr,
    output logic           wValid,
    input  logic           wReady,
    output cachePkg::wordT wData,
    output logic           wLast,
    // write response, accepted and dropped
    input  logic           bValid,
    output logic           bReady
);
    import cachePkg::*;

    tagT      reqTag;
    setT      set;
    offsetT   offset;
    logic     hit;
    wayT      hitWay;
    wayT      victimWay;
    tagT      victimTag;
    logic     victimDirty;
    wayT      lineWay;
    logic     saveVictim;
    logic     tagWrite;
    logic     validSet;
    logic     dirtyWrite;
    logic     dirtyValue;
    logic     dataWrite;
    lineT     writeLine;
    lineMaskT byteEnable;
    lineT     readLine;

    // address split by bit range
    assign reqTag = addr[31:8];
    assign set    = addr[7:4];
    assign offset = addr[3:0];

    // write responses are never waited for
    assign bReady = 1'b1;

    cacheControl control (
        .clock(clock), .reset(reset),
        .valid(valid), .write(write),
        .reqTag(reqTag), .set(set), .offset(offset),
        .wdata(wdata), .wmask(wmask),
        .hit(hit), .hitWay(hitWay), .victimWay(victimWay),
        .victimTag(victimTag), .victimDirty(victimDirty), .readLine(readLine),
        .dataOk(dataOk), .saveVictim(saveVictim), .lineWay(lineWay),
        .tagWrite(tagWrite), .validSet(validSet),
        .dirtyWrite(dirtyWrite), .dirtyValue(dirtyValue),
        .dataWrite(dataWrite), .writeLine(writeLine), .byteEnable(byteEnable),
        .arValid(arValid), .arReady(arReady), .arAddr(arAddr),
        .rValid(rValid), .rLast(rLast), .rData(rData), .rReady(rReady),
        .awValid(awValid), .awReady(awReady), .awAddr(awAddr),
        .wValid(wValid), .wReady(wReady), .wData(wData), .wLast(wLast)
    );

    tagStore tags (
        .clock(clock), .reset(reset),
        .set(set), .reqTag(reqTag), .lineWay(lineWay),
        .tagWrite(tagWrite), .validSet(validSet),
        .dirtyWrite(dirtyWrite), .dirtyValue(dirtyValue),
        .hit(hit), .hitWay(hitWay),
        .victimTag(victimTag), .victimDirty(victimDirty)
    );

    dataStore data (
        .clock(clock),
        .set(set), .lineWay(lineWay), .offset(offset),
        .dataWrite(dataWrite), .writeLine(writeLine), .byteEnable(byteEnable),
        .readLine(readLine), .readWord(rdata)
    );

    victimLfsr #(.lfsrSeed(lfsrSeed)) victim (
        .clock(clock), .reset(reset),
        .saveVictim(saveVictim), .victimWay(victimWay)
    );

endmodule

//--- verilog/cacheControl.sv
module cacheControl (
    input  logic               clock,
    input  logic               reset,
    input  logic               valid,
    input  logic               write,
    input  cachePkg::tagT      reqTag,
    input  cachePkg::setT      set,
    input  cachePkg::offsetT   offset,
    input  cachePkg::wordT     wdata,
    input  cachePkg::maskT     wmask,
    input  logic               hit,
    input  cachePkg::wayT      hitWay,
    input  cachePkg::wayT      victimWay,
    input  cachePkg::tagT      victimTag,
    input  logic               victimDirty,
    input  cachePkg::lineT     readLine,
    output logic               dataOk,
    output logic               saveVictim,
    output cachePkg::wayT      lineWay,
    output logic               tagWrite,
    output logic               validSet,
    output logic               dirtyWrite,
    output logic               dirtyValue,
    output logic               dataWrite,
    output cachePkg::lineT     writeLine,
    output cachePkg::lineMaskT byteEnable,
    output logic               arValid,
    input  logic               arReady,
    output cachePkg::addrT     arAddr,
    input  logic               rValid,
    input  logic               rLast,
    input  cachePkg::wordT     rData,
    output logic               rReady,
    output logic               awValid,
    input  logic               awReady,
    output cachePkg::addrT     awAddr,
    output logic               wValid,
    input  logic               wReady,
    output cachePkg::wordT     wData,
    output logic               wLast
);
    import cachePkg::*;

    cacheStateT state;
    cacheStateT nextState;
    logic       beat;
    logic       inLookup;
    logic       inMiss;
    logic       inReplace;
    logic       inRefill;
    logic       writeHit;
    logic       arFire;
    logic       rFire;
    logic       awFire;
    logic       wFire;
    logic [6:0] bitShift;

    assign inLookup  = (state == stLookup);
    assign inMiss    = (state == stMiss);
    assign inReplace = (state == stReplace);
    assign inRefill  = (state == stRefill);

    // handshakes
    assign arFire = arValid && arReady;
    assign rFire  = rValid && rReady;
    assign awFire = awValid && awReady;
    assign wFire  = wValid && wReady;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (valid) begin
                    nextState = stLookup;
                end
            end
            stLookup: begin
                nextState = hit ? stIdle : stMiss;
            end
            stMiss: begin
                // dirty victim goes out first, then the refill
                if (victimDirty && awFire) begin
                    nextState = stReplace;
                end else if (!victimDirty && arFire) begin
                    nextState = stRefill;
                end
            end
            stReplace: begin
                if (wFire && wLast) begin
                    nextState = stMiss;
                end
            end
            stRefill: begin
                // back to lookup, which now hits
                if (rFire && rLast) begin
                    nextState = stLookup;
                end
            end
            default: begin
                nextState = stIdle;
            end
        endcase
    end

    // burst beat, cleared after the last beat
    always_ff @(posedge clock) begin
        if (reset) begin
            beat <= 1'b0;
        end else if (wFire) begin
            beat <= !wLast;
        end else if (rFire) begin
            beat <= !rLast;
        end
    end

    // cpu side
    assign dataOk     = inLookup && hit;
    assign writeHit   = inLookup && hit && write;
    assign saveVictim = inLookup && !hit;
    // hit way until the miss is taken, victim way afterwards
    assign lineWay    = (state == stIdle || inLookup) ? hitWay : victimWay;

    // byte offset in bits
    assign bitShift = {offset, 3'b000};

    // line write data, refill beat or shifted cpu word
    always_comb begin
        if (inRefill) begin
            writeLine  = beat ? {rData, 64'b0} : {64'b0, rData};
            byteEnable = beat ? 16'hff00 : 16'h00ff;
        end else begin
            writeLine  = {64'b0, wdata} << bitShift;
            byteEnable = {8'b0, wmask} << offset;
        end
    end

    assign dataWrite  = writeHit || rFire;
    // tag goes in with the first beat
    assign tagWrite   = rFire && !beat;
    assign validSet   = rFire && rLast;
    // set on a write hit, cleared by refill end or write-back end
    assign dirtyWrite = writeHit || (rFire && rLast) || (wFire && wLast);
    assign dirtyValue = writeHit;

    // read burst for the missing line
    assign arValid = inMiss && !victimDirty;
    assign arAddr  = {reqTag, set, 4'b0000};
    assign rReady  = inRefill;

    // write-back burst of the victim line
    assign awValid = inMiss && victimDirty;
    assign awAddr  = {victimTag, set, 4'b0000};
    assign wValid  = inReplace;
    assign wData   = beat ? readLine[127:64] : readLine[63:0];
    assign wLast   = inReplace && beat;

endmodule

//--- verilog/dataStore.sv
module dataStore (
    input  logic               clock,
    input  cachePkg::setT      set,
    input  cachePkg::wayT      lineWay,
    input  cachePkg::offsetT   offset,
    input  logic               dataWrite,
    input  cachePkg::lineT     writeLine,
    input  cachePkg::lineMaskT byteEnable,
    output cachePkg::lineT     readLine,
    output cachePkg::wordT     readWord
);
    import cachePkg::*;

    lineT                              lines [setCount*wayCount];
    logic [$bits(setT)+$bits(wayT)-1:0] lineIndex;
    lineT                              shiftedLine;

    // set and way give the line slot
    assign lineIndex = {set, lineWay};

    // byte-enabled write
    always_ff @(posedge clock) begin
        if (dataWrite) begin
            for (int b = 0; b < $bits(lineMaskT); b++) begin
                if (byteEnable[b]) begin
                    lines[lineIndex][b*8 +: 8] <= writeLine[b*8 +: 8];
                end
            end
        end
    end

    // combinational read of the whole line
    assign readLine = lines[lineIndex];

    // align to the byte offset
    // upper bytes fill with zero past the line end
    assign shiftedLine = readLine >> {offset, 3'b000};
    assign readWord    = shiftedLine[63:0];

endmodule

//--- verilog/tagStore.sv
module tagStore (
    input  logic          clock,
    input  logic          reset,
    input  cachePkg::setT set,
    input  cachePkg::tagT reqTag,
    input  cachePkg::wayT lineWay,
    input  logic          tagWrite,
    input  logic          validSet,
    input  logic          dirtyWrite,
    input  logic          dirtyValue,
    output logic          hit,
    output cachePkg::wayT hitWay,
    output cachePkg::tagT victimTag,
    output logic          victimDirty
);
    import cachePkg::*;

    tagT                 tags [setCount][wayCount];
    logic [wayCount-1:0] validBits [setCount];
    logic [wayCount-1:0] dirtyBits [setCount];
    logic [wayCount-1:0] wayMatch;

    // tag payload
    always_ff @(posedge clock) begin
        if (tagWrite) begin
            tags[set][lineWay] <= reqTag;
        end
    end

    // line state bits
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < setCount; s++) begin
                validBits[s] <= '0;
                dirtyBits[s] <= '0;
            end
        end else begin
            if (validSet) begin
                validBits[set][lineWay] <= 1'b1;
            end
            if (dirtyWrite) begin
                dirtyBits[set][lineWay] <= dirtyValue;
            end
        end
    end

    // four-way compare, highest matching way wins
    always_comb begin
        hitWay = '0;
        for (int w = 0; w < wayCount; w++) begin
            wayMatch[w] = validBits[set][w] && (tags[set][w] == reqTag);
            if (wayMatch[w]) begin
                hitWay = wayT'(w);
            end
        end
    end

    assign hit = |wayMatch;

    // state of the selected way
    assign victimTag   = tags[set][lineWay];
    // only a valid line needs write-back
    assign victimDirty = validBits[set][lineWay] && dirtyBits[set][lineWay];

endmodule

//--- verilog/victimLfsr.sv
module victimLfsr #(
    parameter logic [15:0] lfsrSeed = 16'd1
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          saveVictim,
    output cachePkg::wayT victimWay
);
    logic [15:0] lfsr;
    logic        feedback;

    // taps 0, 2, 3, 5
    assign feedback = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];

    // right shift, free running
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= lfsrSeed;
        end else begin
            lfsr <= {feedback, lfsr[15:1]};
        end
    end

    // victim held for the whole miss
    always_ff @(posedge clock) begin
        if (reset) begin
            victimWay <= '0;
        end else if (saveVictim) begin
            victimWay <= lfsr[1:0];
        end
    end

endmodule

//--- verilog/cachePkg.sv
package cachePkg;

    // byte address on both the cpu and the memory side
    typedef logic [31:0] addrT;

    // address split: tag | set | byte offset
    typedef logic [23:0] tagT;
    typedef logic [3:0]  setT;
    typedef logic [3:0]  offsetT;

    // way number inside a set
    typedef logic [1:0]  wayT;

    // data paths
    typedef logic [63:0]  wordT;
    typedef logic [127:0] lineT;

    // cpu byte mask and per-byte line write enable
    typedef logic [7:0]  maskT;
    typedef logic [15:0] lineMaskT;

    // controller states
    typedef enum logic [2:0] {
        stIdle,
        stLookup,
        stMiss,
        stReplace,
        stRefill
    } cacheStateT;

    // geometry
    localparam int wayCount = 4;
    localparam int setCount = 16;

endpackage
